// ==== hdl/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;
    localparam int OP_W       = 6;

    localparam logic [OP_W-1:0] OPC_RTYPE = 6'b000000;
    localparam logic [OP_W-1:0] OPC_ADDI  = 6'b001000;
    localparam logic [OP_W-1:0] OPC_ADDIU = 6'b001001;
    localparam logic [OP_W-1:0] OPC_SLTI  = 6'b001010;
    localparam logic [OP_W-1:0] OPC_SLTIU = 6'b001011;
    localparam logic [OP_W-1:0] OPC_ANDI  = 6'b001100;
    localparam logic [OP_W-1:0] OPC_ORI   = 6'b001101;
    localparam logic [OP_W-1:0] OPC_XORI  = 6'b001110;
    localparam logic [OP_W-1:0] OPC_LUI   = 6'b001111;

    localparam logic [OP_W-1:0] FN_SLL  = 6'b000000;
    localparam logic [OP_W-1:0] FN_SRL  = 6'b000010;
    localparam logic [OP_W-1:0] FN_SRA  = 6'b000011;
    localparam logic [OP_W-1:0] FN_SLLV = 6'b000100;
    localparam logic [OP_W-1:0] FN_SRLV = 6'b000110;
    localparam logic [OP_W-1:0] FN_SRAV = 6'b000111;
    localparam logic [OP_W-1:0] FN_ADD  = 6'b100000;
    localparam logic [OP_W-1:0] FN_ADDU = 6'b100001;
    localparam logic [OP_W-1:0] FN_SUB  = 6'b100010;
    localparam logic [OP_W-1:0] FN_SUBU = 6'b100011;
    localparam logic [OP_W-1:0] FN_AND  = 6'b100100;
    localparam logic [OP_W-1:0] FN_OR   = 6'b100101;
    localparam logic [OP_W-1:0] FN_XOR  = 6'b100110;
    localparam logic [OP_W-1:0] FN_NOR  = 6'b100111;
    localparam logic [OP_W-1:0] FN_SLT  = 6'b101010;
    localparam logic [OP_W-1:0] FN_SLTU = 6'b101011;

    // R-type operations reuse the funct value, I-type operations the opcode value
    localparam logic [OP_W-1:0] ALU_SLL   = FN_SLL;
    localparam logic [OP_W-1:0] ALU_SRL   = FN_SRL;
    localparam logic [OP_W-1:0] ALU_SRA   = FN_SRA;
    localparam logic [OP_W-1:0] ALU_SLLV  = FN_SLLV;
    localparam logic [OP_W-1:0] ALU_SRLV  = FN_SRLV;
    localparam logic [OP_W-1:0] ALU_SRAV  = FN_SRAV;
    localparam logic [OP_W-1:0] ALU_ADD   = FN_ADD;
    localparam logic [OP_W-1:0] ALU_ADDU  = FN_ADDU;
    localparam logic [OP_W-1:0] ALU_SUB   = FN_SUB;
    localparam logic [OP_W-1:0] ALU_SUBU  = FN_SUBU;
    localparam logic [OP_W-1:0] ALU_AND   = FN_AND;
    localparam logic [OP_W-1:0] ALU_OR    = FN_OR;
    localparam logic [OP_W-1:0] ALU_XOR   = FN_XOR;
    localparam logic [OP_W-1:0] ALU_NOR   = FN_NOR;
    localparam logic [OP_W-1:0] ALU_SLT   = FN_SLT;
    localparam logic [OP_W-1:0] ALU_SLTU  = FN_SLTU;
    localparam logic [OP_W-1:0] ALU_ADDI  = OPC_ADDI;
    localparam logic [OP_W-1:0] ALU_ADDIU = OPC_ADDIU;
    localparam logic [OP_W-1:0] ALU_SLTI  = OPC_SLTI;
    localparam logic [OP_W-1:0] ALU_SLTIU = OPC_SLTIU;
    localparam logic [OP_W-1:0] ALU_ANDI  = OPC_ANDI;
    localparam logic [OP_W-1:0] ALU_ORI   = OPC_ORI;
    localparam logic [OP_W-1:0] ALU_XORI  = OPC_XORI;
    localparam logic [OP_W-1:0] ALU_LUI   = OPC_LUI;
    localparam logic [OP_W-1:0] ALU_IDLE  = 6'b111111;

    typedef struct packed {
        logic [OP_W-1:0]       opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [OP_W-1:0]       funct;
    } r_instr_t;

    typedef struct packed {
        logic [OP_W-1:0]       opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm16;
    } i_instr_t;

    typedef union packed {
        r_instr_t r;
        i_instr_t i;
    } instr_u;

    typedef struct packed {
        logic                  valid;
        logic [OP_W-1:0]       alu_op;
        logic [DATA_W-1:0]     operand1;
        logic [DATA_W-1:0]     operand2;
        logic [4:0]            shamt;
        logic [REG_ADDR_W-1:0] dest;
        logic                  write_en;
    } decoded_t;

    typedef struct packed {
        logic                  valid;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     data;
    } wb_t;

endpackage

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu
    import mips_pkg::*;
(
    input  logic signed [DATA_W-1:0] i_operand1,
    input  logic signed [DATA_W-1:0] i_operand2,
    input  logic        [OP_W-1:0]   i_alu_op,
    input  logic        [4:0]        i_shamt,
    output logic        [DATA_W-1:0] o_result
);

    logic [4:0] var_shamt;

    assign var_shamt = i_operand2[4:0];  // Variable shifts only look at 5 bits

    always_comb begin
        case (i_alu_op)
            ALU_IDLE: o_result = '0;

            ALU_SLL:  o_result = i_operand1 << i_shamt;
            ALU_SRL:  o_result = i_operand1 >> i_shamt;
            ALU_SRA:  o_result = i_operand1 >>> i_shamt;  // Operand is signed so sign fills
            ALU_SLLV: o_result = i_operand1 << var_shamt;
            ALU_SRLV: o_result = i_operand1 >> var_shamt;
            ALU_SRAV: o_result = i_operand1 >>> var_shamt;

            // No overflow trap, so ADD and SUB wrap like their unsigned forms
            ALU_ADD:  o_result = i_operand1 + i_operand2;
            ALU_ADDU: o_result = $unsigned(i_operand1) + $unsigned(i_operand2);
            ALU_SUB:  o_result = i_operand1 - i_operand2;
            ALU_SUBU: o_result = $unsigned(i_operand1) - $unsigned(i_operand2);
            ALU_AND:  o_result = i_operand1 & i_operand2;
            ALU_OR:   o_result = i_operand1 | i_operand2;
            ALU_XOR:  o_result = i_operand1 ^ i_operand2;
            ALU_NOR:  o_result = ~(i_operand1 | i_operand2);
            ALU_SLT: begin
                o_result = (i_operand1 < i_operand2) ? 32'd1 : 32'd0;
            end
            ALU_SLTU: begin
                o_result = ($unsigned(i_operand1) < $unsigned(i_operand2)) ? 32'd1 : 32'd0;
            end

            ALU_ADDI:  o_result = i_operand1 + i_operand2;
            ALU_ADDIU: o_result = $unsigned(i_operand1) + $unsigned(i_operand2);
            ALU_SLTI: begin
                o_result = (i_operand1 < i_operand2) ? 32'd1 : 32'd0;
            end
            ALU_SLTIU: begin
                o_result = ($unsigned(i_operand1) < $unsigned(i_operand2)) ? 32'd1 : 32'd0;
            end
            ALU_ANDI:  o_result = i_operand1 & i_operand2;
            ALU_ORI:   o_result = i_operand1 | i_operand2;
            ALU_XORI:  o_result = i_operand1 ^ i_operand2;
            ALU_LUI:   o_result = i_operand2;  // Immediate arrives already in the upper half

            default:   o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
    import mips_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_instr_valid,
    input  instr_u                i_instr,
    input  logic [DATA_W-1:0]     i_rs_data,
    input  logic [DATA_W-1:0]     i_rt_data,
    input  wb_t                   i_fwd,
    output logic [REG_ADDR_W-1:0] o_rs_addr,
    output logic [REG_ADDR_W-1:0] o_rt_addr,
    output decoded_t              o_dec
);

    logic [DATA_W-1:0] rs_val;
    logic [DATA_W-1:0] rt_val;
    logic [DATA_W-1:0] imm_sext;
    logic [DATA_W-1:0] imm_zext;
    logic              supported;
    decoded_t          dec_next;

    // rs and rt sit at the same bits in both views
    assign o_rs_addr = i_instr.r.rs;
    assign o_rt_addr = i_instr.r.rt;

    // Result of the instruction ahead wins over the register file
    assign rs_val = (i_fwd.valid && (i_fwd.dest != '0) && (i_fwd.dest == i_instr.r.rs)) ?
                    i_fwd.data : i_rs_data;
    assign rt_val = (i_fwd.valid && (i_fwd.dest != '0) && (i_fwd.dest == i_instr.r.rt)) ?
                    i_fwd.data : i_rt_data;

    assign imm_sext = {{(DATA_W-16){i_instr.i.imm16[15]}}, i_instr.i.imm16};
    assign imm_zext = {{(DATA_W-16){1'b0}}, i_instr.i.imm16};

    always_comb begin
        dec_next          = '0;
        dec_next.valid    = i_instr_valid;
        dec_next.alu_op   = ALU_IDLE;
        dec_next.operand1 = rs_val;
        dec_next.operand2 = rt_val;
        dec_next.shamt    = i_instr.r.shamt;
        dec_next.dest     = i_instr.r.rd;
        supported         = 1'b0;

        if (i_instr.r.opcode == OPC_RTYPE) begin
            case (i_instr.r.funct)
                FN_SLL, FN_SRL, FN_SRA: begin
                    dec_next.operand1 = rt_val;
                    supported         = 1'b1;
                end
                FN_SLLV, FN_SRLV, FN_SRAV: begin
                    dec_next.operand1 = rt_val;
                    dec_next.operand2 = rs_val;  // Shift amount taken from its low bits
                    supported         = 1'b1;
                end
                FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR,
                FN_SLT, FN_SLTU: begin
                    supported = 1'b1;
                end
                default: begin
                    supported = 1'b0;
                end
            endcase
            if (supported) begin
                dec_next.alu_op = i_instr.r.funct;
            end
        end else begin
            dec_next.dest     = i_instr.i.rt;
            dec_next.operand2 = imm_sext;
            case (i_instr.i.opcode)
                OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU: begin
                    supported = 1'b1;
                end
                OPC_ANDI, OPC_ORI, OPC_XORI: begin
                    dec_next.operand2 = imm_zext;
                    supported         = 1'b1;
                end
                OPC_LUI: begin
                    dec_next.operand2 = {i_instr.i.imm16, 16'h0000};
                    supported         = 1'b1;
                end
                default: begin
                    supported = 1'b0;
                end
            endcase
            if (supported) begin
                dec_next.alu_op = i_instr.i.opcode;
            end
        end

        dec_next.write_en = i_instr_valid && supported && (dec_next.dest != '0);
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_dec.valid    <= 1'b0;
            o_dec.write_en <= 1'b0;
        end else begin
            o_dec <= dec_next;
        end
    end

    // A forwarded result is always a register write, and r0 is never a write target
    a_no_fwd_r0 : assert property (@(posedge i_clk) disable iff (i_rst)
        i_fwd.valid |-> (i_fwd.dest != '0));

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file
    import mips_pkg::*;
(
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic [REG_ADDR_W-1:0] i_rs_addr,
    input  logic [REG_ADDR_W-1:0] i_rt_addr,
    input  wb_t                   i_wb,
    output logic [DATA_W-1:0]     o_rs_data,
    output logic [DATA_W-1:0]     o_rt_data
);

    logic [DATA_W-1:0] regs [NUM_REGS];
    logic              wr_en;

    assign wr_en = i_wb.valid && (i_wb.dest != '0);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int n = 0; n < NUM_REGS; n++) begin
                regs[n] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.dest] <= i_wb.data;
        end
    end

    // A read in the cycle of the write already returns the new word
    assign o_rs_data = (i_rs_addr == '0)                    ? '0 :
                       (wr_en && (i_wb.dest == i_rs_addr)) ? i_wb.data :
                       regs[i_rs_addr];
    assign o_rt_data = (i_rt_addr == '0)                    ? '0 :
                       (wr_en && (i_wb.dest == i_rt_addr)) ? i_wb.data :
                       regs[i_rt_addr];

    a_wr_data_known : assert property (@(posedge i_clk) disable iff (i_rst)
        wr_en |-> !$isunknown(i_wb.data));

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import mips_pkg::*;
(
    input  logic     i_clk,
    input  logic     i_rst,
    input  decoded_t i_dec,
    output wb_t      o_fwd,
    output wb_t      o_wb
);

    logic [DATA_W-1:0] alu_result;

    alu u_alu (
        .i_operand1 (i_dec.operand1),
        .i_operand2 (i_dec.operand2),
        .i_alu_op   (i_dec.alu_op),
        .i_shamt    (i_dec.shamt),
        .o_result   (alu_result)
    );

    // Forwarding carries what o_wb takes at the next edge
    assign o_fwd.valid = i_dec.valid && i_dec.write_en;
    assign o_fwd.dest  = i_dec.dest;
    assign o_fwd.data  = alu_result;

    always_ff @(posedge i_clk) begin
        o_wb.data <= alu_result;
        if (i_rst) begin
            o_wb.valid <= 1'b0;
            o_wb.dest  <= '0;
        end else begin
            o_wb.valid <= i_dec.valid;
            o_wb.dest  <= i_dec.write_en ? i_dec.dest : '0;  // Unwritten results report r0
        end
    end

    // A write is only requested by a valid instruction
    a_write_needs_valid : assert property (@(posedge i_clk) disable iff (i_rst)
        i_dec.write_en |-> i_dec.valid);

endmodule

`default_nettype wire

// ==== hdl/mips_execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_execute_unit
    import mips_pkg::*;
(
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_instr_valid,
    input  instr_u i_instr,
    output wb_t    o_wb
);

    logic [REG_ADDR_W-1:0] rs_addr;
    logic [REG_ADDR_W-1:0] rt_addr;
    logic [DATA_W-1:0]     rs_data;
    logic [DATA_W-1:0]     rt_data;
    wb_t                   fwd;
    decoded_t              dec;

    instr_decoder u_instr_decoder (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .i_rs_data     (rs_data),
        .i_rt_data     (rt_data),
        .i_fwd         (fwd),
        .o_rs_addr     (rs_addr),
        .o_rt_addr     (rt_addr),
        .o_dec         (dec)
    );

    // The write-back record is also the register file write port
    register_file u_register_file (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_rs_addr (rs_addr),
        .i_rt_addr (rt_addr),
        .i_wb      (o_wb),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    execute_stage u_execute_stage (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .i_dec (dec),
        .o_fwd (fwd),
        .o_wb  (o_wb)
    );

endmodule

`default_nettype wire

// ==== test/alu_ref_model.svh ====
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

logic [31:0] model_regs [32];  // Register contents after every issued instruction

task automatic clear_model();
    for (int n = 0; n < 32; n++) begin
        model_regs[n] = '0;
    end
endtask

// Computes the write-back data and dest of one instruction and commits it to the model
function automatic logic [31:0] predict_instr(input logic [31:0] instr,
                                              output logic [4:0] dest);
    logic [5:0]  opc;
    logic [5:0]  fn;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  sh;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_s;
    logic [31:0] imm_z;
    logic [31:0] res;
    logic        ok;

    opc   = instr[31:26];
    rs    = instr[25:21];
    rt    = instr[20:16];
    sh    = instr[10:6];
    fn    = instr[5:0];
    a     = model_regs[rs];
    b     = model_regs[rt];
    imm_s = {{16{instr[15]}}, instr[15:0]};
    imm_z = {16'h0000, instr[15:0]};
    res   = '0;
    ok    = 1'b1;

    if (opc == OPC_RTYPE) begin
        dest = instr[15:11];
        case (fn)
            FN_SLL:          res = b << sh;
            FN_SRL:          res = b >> sh;
            FN_SRA:          res = $signed(b) >>> sh;
            FN_SLLV:         res = b << a[4:0];  // Only the low 5 bits of rs count
            FN_SRLV:         res = b >> a[4:0];
            FN_SRAV:         res = $signed(b) >>> a[4:0];
            FN_ADD, FN_ADDU: res = a + b;
            FN_SUB, FN_SUBU: res = a - b;
            FN_AND:          res = a & b;
            FN_OR:           res = a | b;
            FN_XOR:          res = a ^ b;
            FN_NOR:          res = ~(a | b);
            FN_SLT:          res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FN_SLTU:         res = (a < b) ? 32'd1 : 32'd0;
            default:         ok = 1'b0;
        endcase
    end else begin
        dest = rt;
        case (opc)
            OPC_ADDI, OPC_ADDIU: res = a + imm_s;
            OPC_SLTI:            res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
            OPC_SLTIU:           res = (a < imm_s) ? 32'd1 : 32'd0;
            OPC_ANDI:            res = a & imm_z;
            OPC_ORI:             res = a | imm_z;
            OPC_XORI:            res = a ^ imm_z;
            OPC_LUI:             res = {instr[15:0], 16'h0000};
            default:             ok = 1'b0;
        endcase
    end

    if (!ok) begin
        res  = '0;
        dest = '0;
    end
    if (dest != '0) begin
        model_regs[dest] = res;
    end
    predict_instr = res;
endfunction

`endif

// ==== test/tb_mips_execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_execute_unit
    import mips_pkg::*;
;

    typedef struct packed {
        logic [31:0] due;
        logic [4:0]  dest;
        logic [31:0] data;
    } exp_t;

    logic   i_clk;
    logic   i_rst;
    logic   i_instr_valid;
    instr_u i_instr;
    wb_t    o_wb;

    int   errors    = 0;
    int   checked   = 0;
    int   cycle_cnt = 0;
    int   seed      = 32'h62bc;
    exp_t exp_q [$];

    `include "alu_ref_model.svh"

    mips_execute_unit u_mips_execute_unit (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_instr_valid (i_instr_valid),
        .i_instr       (i_instr),
        .o_wb          (o_wb)
    );

    initial begin
        i_clk = 1'b0;
        forever #5 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic logic [31:0] rand_word();
        rand_word = $random(seed);
    endfunction

    function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [4:0] rd,
                                           input logic [4:0] sh);
        r_type = {OPC_RTYPE, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] i_type(input logic [5:0] opc, input logic [4:0] rs,
                                           input logic [4:0] rt, input logic [15:0] imm);
        i_type = {opc, rs, rt, imm};
    endfunction

    // Write-backs are checked mid-cycle, in issue order and with a latency of 2 edges
    always @(negedge i_clk) begin : monitor
        exp_t e;
        if (!i_rst && o_wb.valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Write-back at %0t ns with no instruction pending", $time);
            end else begin
                e = exp_q.pop_front();
                check_value("write-back cycle", cycle_cnt, e.due);
                check_value("o_wb.dest", o_wb.dest, e.dest);
                check_value("o_wb.data", o_wb.data, e.data);
                checked++;
            end
        end else if (exp_q.size() != 0 && cycle_cnt > exp_q[0].due) begin
            errors++;
            $display("Write-back missing at %0t ns", $time);
            void'(exp_q.pop_front());
        end
    end

    task automatic issue(input logic [31:0] instr);
        exp_t       e;
        logic [4:0] d;
        e.data = predict_instr(instr, d);
        e.dest = d;
        e.due  = cycle_cnt + 2;
        exp_q.push_back(e);
        i_instr_valid = 1'b1;
        i_instr       = instr;
        @(posedge i_clk);
        #1;
        i_instr_valid = 1'b0;
    endtask

    task automatic idle_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(posedge i_clk);
            n++;
        end
        #1;
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timeout at %0t ns: %0d write-backs never arrived", $time, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic test_reset_idle();
        logic [31:0] rnd;
        for (int n = 0; n < 10; n++) begin
            @(negedge i_clk);
            check_value("o_wb.valid while idle", o_wb.valid, 1'b0);
        end
        idle_cycle();
        rnd = rand_word();
        issue(i_type(OPC_ORI, 5'd0, 5'd1, rnd[15:0] | 16'h8000));  // Top bit set to see zero fill
        wait_drain();
    endtask

    // Odd registers get a negative value
    task automatic load_regs();
        logic [31:0] rnd;
        for (int r = 1; r < 16; r++) begin
            rnd = rand_word();
            rnd[31] = r[0] ? 1'b1 : rnd[31];
            issue(i_type(OPC_LUI, 5'd0, r[4:0], rnd[31:16]));
            issue(i_type(OPC_ORI, r[4:0], r[4:0], rnd[15:0]));
        end
        wait_drain();
    endtask

    task automatic test_itype();
        logic [5:0]  ops [8] = '{OPC_ADDI, OPC_ADDIU, OPC_SLTI, OPC_SLTIU,
                                 OPC_ANDI, OPC_ORI, OPC_XORI, OPC_LUI};
        logic [31:0] rnd;
        load_regs();
        foreach (ops[k]) begin
            repeat (4) begin
                rnd = rand_word();
                issue(i_type(ops[k], {1'b0, rnd[3:0]}, 5'd16 + rnd[7:4], rnd[31:16]));
            end
        end
        wait_drain();
    endtask

    task automatic test_rtype();
        logic [5:0]  fns [10] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_AND,
                                  FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
        logic [31:0] rnd;
        load_regs();
        foreach (fns[k]) begin
            repeat (4) begin
                rnd = rand_word();
                issue(r_type(fns[k], {1'b0, rnd[3:0]}, {1'b0, rnd[7:4]},
                             5'd16 + rnd[11:8], 5'd0));
            end
        end
        wait_drain();
    endtask

    task automatic test_shifts();
        logic [5:0]  fixed [3] = '{FN_SLL, FN_SRL, FN_SRA};
        logic [5:0]  vars [3]  = '{FN_SLLV, FN_SRLV, FN_SRAV};
        logic [31:0] rnd;
        foreach (fixed[k]) begin
            repeat (4) begin
                rnd = rand_word();
                issue(r_type(fixed[k], 5'd0, {1'b0, rnd[3:0]}, 5'd16 + rnd[6:4], rnd[12:8]));
            end
        end
        foreach (vars[k]) begin
            repeat (4) begin
                rnd = rand_word();
                issue(i_type(OPC_ORI, 5'd0, 5'd28, rnd[31:16] | 16'h0020));  // Amount above 31
                issue(r_type(vars[k], 5'd28, {1'b0, rnd[3:0]}, 5'd16 + rnd[6:4], 5'd0));
            end
        end
        wait_drain();
    endtask

    // Each link reads the previous result, gap idle cycles apart
    task automatic run_chain(input int gap);
        logic [5:0]  fns [4] = '{FN_ADDU, FN_SUBU, FN_XOR, FN_SLLV};
        logic [31:0] rnd;
        logic [4:0]  prev;
        logic [4:0]  d;
        prev = 5'd1;
        for (int i = 0; i < 12; i++) begin
            rnd = rand_word();
            d   = 5'd24 + i[1:0];
            if (i % 3 == 2) begin
                issue(i_type(OPC_ADDIU, prev, d, rnd[15:0]));
            end else begin
                issue(r_type(fns[rnd[17:16]], prev, (i % 2 == 0) ? prev : {1'b0, rnd[3:0]},
                             d, 5'd0));
            end
            repeat (gap) idle_cycle();
            prev = d;
        end
        wait_drain();
    endtask

    task automatic test_r0_unsupported();
        issue(r_type(FN_ADDU, 5'd1, 5'd2, 5'd0, 5'd0));
        issue(r_type(FN_OR, 5'd0, 5'd0, 5'd27, 5'd0));
        issue(r_type(6'b011000, 5'd3, 5'd4, 5'd5, 5'd0));  // MULT funct
        issue(i_type(6'b100011, 5'd1, 5'd6, 16'h0040));    // LW opcode
        for (int r = 0; r < 32; r++) begin
            issue(r_type(FN_OR, r[4:0], 5'd0, 5'd0, 5'd0));  // Reads each register out
        end
        wait_drain();
    endtask

    initial begin
        i_rst         = 1'b1;
        i_instr_valid = 1'b0;
        i_instr       = '0;
        clear_model();
        repeat (5) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        test_reset_idle();
        test_itype();
        test_rtype();
        test_shifts();
        load_regs();
        run_chain(0);
        run_chain(1);
        test_r0_unsupported();

        $display("Summary: %0d errors in %0d write-backs", errors, checked);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== mips_execute_unit.f ====
+incdir+test
hdl/mips_pkg.sv
hdl/alu.sv
hdl/instr_decoder.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/mips_execute_unit.sv
test/tb_mips_execute_unit.sv
